// File: logic/decode_pkg.sv
package decode_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;
    typedef logic [1:0]           ls_size_t;

    localparam funct3_t  funct3_add_sub = 3'b000;
    localparam funct3_t  funct3_srl_sra = 3'b101;
    localparam funct7_t  funct7_alt     = 7'b0100000; // SUB and SRA
    localparam ls_size_t ls_word        = 2'b10;
    localparam ls_size_t ls_bad         = 2'b11;       // No 64-bit access on RV32

    // Major opcodes, instr bits 6..0
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add_sub = 3'b000,
        alu_sll     = 3'b001,
        alu_slt     = 3'b010,
        alu_sltu    = 3'b011,
        alu_xor     = 3'b100,
        alu_srl_sra = 3'b101,
        alu_or      = 3'b110,
        alu_and     = 3'b111
    } alu_func_e;

    typedef enum logic [1:0] {
        sel_reg  = 2'b00,
        sel_imm  = 2'b01,
        sel_pc   = 2'b10,
        sel_zero = 2'b11
    } alu_sel_e;

    typedef enum logic [1:0] {
        wr_alu     = 2'b00,
        wr_load    = 2'b01,
        wr_next_pc = 2'b10
    } write_sel_e;

    typedef struct packed {
        alu_func_e  alu_func;
        logic       alu_func_sel;  // SUB or SRA
        alu_sel_e   alu_a_select;
        alu_sel_e   alu_b_select;
        write_sel_e write_select;
        logic       cmp_less;
        logic       cmp_unsigned;
        logic       cmp_negate;
        logic       jump;
        logic       branch;
        logic       load;
        logic       store;
        ls_size_t   ls_size;
        logic       load_signed;
        reg_idx_t   rd_addr;
        logic       exception;     // Illegal instruction
    } decode_ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t next_pc;
        word_t rs1_data;
        word_t rs2_data;
        word_t imm;
    } decode_ops_t;

endpackage

// File: logic/imm_gen.sv
`timescale 1ns/10ps

module imm_gen import decode_pkg::*; (
    input  word_t instr,
    output word_t imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            op_lui,
            op_auipc: begin
                imm = {instr[31:12], 12'b0}; // U format
            end
            op_jal: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            op_jalr,
            op_load,
            op_op_imm: begin
                imm = {{20{instr[31]}}, instr[31:20]}; // I format
            end
            op_store: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = '0; // OP, FENCE, SYSTEM and unknown
            end
        endcase
    end

endmodule

// File: logic/ctrl_decoder.sv
`timescale 1ns/10ps

module ctrl_decoder import decode_pkg::*; (
    input  word_t        instr,
    output decode_ctrl_t ctrl
);

    opcode_e  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    reg_idx_t rd;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    always_comb begin
        ctrl = '0; // Unused fields stay zero
        case (opcode)
            op_lui: begin
                ctrl.alu_func     = alu_or;
                ctrl.alu_a_select = sel_zero;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_alu;
                ctrl.rd_addr      = rd;
            end
            op_auipc: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_pc;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_alu;
                ctrl.rd_addr      = rd;
            end
            op_jal: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_pc;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_next_pc; // Link address
                ctrl.branch       = 1'b1;
                ctrl.jump         = 1'b1;
                ctrl.rd_addr      = rd;
            end
            op_jalr: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_reg;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_next_pc;
                ctrl.branch       = 1'b1;
                ctrl.jump         = 1'b1;
                ctrl.rd_addr      = rd;
                ctrl.exception    = (funct3 != 3'b000);
            end
            op_branch: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_pc; // Target address
                ctrl.alu_b_select = sel_imm;
                ctrl.branch       = 1'b1;
                ctrl.cmp_less     = funct3[2];
                ctrl.cmp_unsigned = funct3[1];
                ctrl.cmp_negate   = funct3[0];
                ctrl.exception    = (funct3[2:1] == 2'b01);
            end
            op_load: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_reg;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_load;
                ctrl.load         = 1'b1;
                ctrl.ls_size      = funct3[1:0];
                ctrl.load_signed  = ~funct3[2];
                ctrl.rd_addr      = rd;
                ctrl.exception    = (funct3[1:0] == ls_bad) ||
                                    (funct3[2] && funct3[1:0] == ls_word); // No LWU
            end
            op_store: begin
                ctrl.alu_func     = alu_add_sub;
                ctrl.alu_a_select = sel_reg;
                ctrl.alu_b_select = sel_imm;
                ctrl.store        = 1'b1;
                ctrl.ls_size      = funct3[1:0];
                ctrl.exception    = (funct3[1:0] == ls_bad) || funct3[2];
            end
            op_op_imm: begin
                ctrl.alu_func     = alu_func_e'(funct3);
                ctrl.alu_func_sel = (funct3 == funct3_srl_sra) && instr[30]; // SRAI only
                ctrl.alu_a_select = sel_reg;
                ctrl.alu_b_select = sel_imm;
                ctrl.write_select = wr_alu;
                ctrl.rd_addr      = rd;
            end
            op_op: begin
                ctrl.alu_func     = alu_func_e'(funct3);
                ctrl.alu_func_sel = instr[30];
                ctrl.alu_a_select = sel_reg;
                ctrl.alu_b_select = sel_reg;
                ctrl.write_select = wr_alu;
                ctrl.rd_addr      = rd;
                ctrl.exception    = (funct7 != '0) &&
                                    !(funct7 == funct7_alt &&
                                      (funct3 == funct3_add_sub || funct3 == funct3_srl_sra));
            end
            op_fence: begin
                ctrl.exception    = (funct3 != 3'b000); // Otherwise a no-op
            end
            default: begin
                ctrl.exception    = 1'b1; // SYSTEM and unknown opcodes
            end
        endcase

        // An illegal instruction must have no side effects
        if (ctrl.exception) begin
            ctrl.rd_addr = '0;
            ctrl.branch  = 1'b0;
            ctrl.jump    = 1'b0;
            ctrl.load    = 1'b0;
            ctrl.store   = 1'b0;
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import decode_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         valid_in,
    input  word_t        instr,
    input  word_t        pc_in,
    input  word_t        next_pc_in,
    input  logic         stall_in,
    input  logic         invalidate,
    input  reg_idx_t     hazard_0,
    input  reg_idx_t     hazard_1,
    output reg_idx_t     rs1_select,
    output reg_idx_t     rs2_select,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output logic         stall_out,
    output logic         valid_out,
    output decode_ctrl_t ctrl,
    output decode_ops_t  ops
);

    word_t        imm;
    decode_ctrl_t ctrl_next;
    decode_ops_t  ops_next;
    logic         hit_0;
    logic         hit_1;
    logic         capture;

    imm_gen imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    ctrl_decoder ctrl_decoder_i (
        .instr (instr),
        .ctrl  (ctrl_next)
    );

    assign rs1_select = instr[19:15];
    assign rs2_select = instr[24:20];

    // x0 is never a real destination
    assign hit_0 = (hazard_0 != '0) && (hazard_0 == rs1_select || hazard_0 == rs2_select);
    assign hit_1 = (hazard_1 != '0) && (hazard_1 == rs1_select || hazard_1 == rs2_select);

    assign stall_out = valid_in && (hit_0 || hit_1);
    assign capture   = valid_in && !stall_out && !invalidate;

    assign ops_next = '{
        pc:       pc_in,
        next_pc:  next_pc_in,
        rs1_data: rs1_data,
        rs2_data: rs2_data,
        imm:      imm
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
            ctrl      <= '0;
        end else if (!stall_in) begin
            valid_out <= capture; // Bubble on hazard or flush
            if (capture) begin
                ctrl <= ctrl_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_in && capture) begin
            ops <= ops_next;
        end
    end

    // Back-pressure freezes the whole output register
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall_in |=> $stable(valid_out) && $stable(ctrl) && $stable(ops)
    ) else $error("decode outputs changed under stall_in");

    a_load_store_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_out |-> !(ctrl.load && ctrl.store)
    ) else $error("decode issued load and store together");

    a_illegal_no_rd: assert property (
        @(posedge clk) disable iff (!arst_n)
        (valid_out && ctrl.exception) |-> (ctrl.rd_addr == '0)
    ) else $error("illegal instruction left rd_addr set");

endmodule

// File: test/decode_checker.sv
`timescale 1ns/10ps

module decode_checker import decode_pkg::*; (
    input logic         clk,
    input logic         arst_n,
    input logic         valid_in,
    input word_t        instr,
    input word_t        pc_in,
    input word_t        next_pc_in,
    input logic         stall_in,
    input logic         invalidate,
    input reg_idx_t     hazard_0,
    input reg_idx_t     hazard_1,
    input reg_idx_t     rs1_select,
    input reg_idx_t     rs2_select,
    input word_t        rs1_data,
    input word_t        rs2_data,
    input logic         stall_out,
    input logic         valid_out,
    input decode_ctrl_t ctrl,
    input decode_ops_t  ops
);

    int           errors    = 0;
    int           checks    = 0;
    logic         exp_valid = 1'b0;
    decode_ctrl_t exp_ctrl  = '0;
    decode_ops_t  exp_ops;
    logic         ops_known = 1'b0; // Ops have no reset value

    function automatic word_t build_imm(word_t i);
        case (i[6:0])
            op_lui, op_auipc: return {i[31:12], 12'h000};
            op_jal:           return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            op_jalr, op_load, op_op_imm: return {{20{i[31]}}, i[31:20]};
            op_store:         return {{20{i[31]}}, i[31:25], i[11:7]};
            op_branch:        return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic is_illegal(word_t i);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = i[14:12];
        f7 = i[31:25];
        case (i[6:0])
            op_lui, op_auipc, op_jal, op_op_imm: return 1'b0;
            op_jalr:   return f3 != 3'd0;
            op_branch: return f3 == 3'd2 || f3 == 3'd3;
            op_load:   return f3 == 3'd3 || f3 == 3'd7 || f3 == 3'd6;
            op_store:  return f3 > 3'd2;
            op_op:     return !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            op_fence:  return f3 != 3'd0;
            default:   return 1'b1;
        endcase
    endfunction

    function automatic decode_ctrl_t predict_ctrl(word_t i);
        decode_ctrl_t c;
        logic         bad;
        c   = '0;
        bad = is_illegal(i);
        case (i[6:0])
            op_lui: begin
                c.alu_func     = alu_or;
                c.alu_a_select = sel_zero;
                c.alu_b_select = sel_imm;
                c.rd_addr      = i[11:7];
            end
            op_auipc: begin
                c.alu_a_select = sel_pc;
                c.alu_b_select = sel_imm;
                c.rd_addr      = i[11:7];
            end
            op_jal, op_jalr: begin
                c.alu_a_select = (i[6:0] == op_jal) ? sel_pc : sel_reg;
                c.alu_b_select = sel_imm;
                c.write_select = wr_next_pc;
                c.jump         = 1'b1;
                c.branch       = 1'b1;
                c.rd_addr      = i[11:7];
            end
            op_branch: begin
                c.alu_a_select = sel_pc;
                c.alu_b_select = sel_imm;
                c.branch       = 1'b1;
                c.cmp_less     = i[14];
                c.cmp_unsigned = i[13];
                c.cmp_negate   = i[12];
            end
            op_load: begin
                c.alu_b_select = sel_imm;
                c.write_select = wr_load;
                c.load         = 1'b1;
                c.ls_size      = i[13:12];
                c.load_signed  = !i[14];
                c.rd_addr      = i[11:7];
            end
            op_store: begin
                c.alu_b_select = sel_imm;
                c.store        = 1'b1;
                c.ls_size      = i[13:12];
            end
            op_op_imm, op_op: begin
                c.alu_func     = alu_func_e'(i[14:12]);
                c.alu_b_select = (i[6:0] == op_op) ? sel_reg : sel_imm;
                c.alu_func_sel = i[30] && (i[6:0] == op_op || i[14:12] == 3'd5);
                c.rd_addr      = i[11:7];
            end
            default: ;
        endcase
        if (bad) begin
            c.rd_addr = '0;
            c.jump    = 1'b0;
            c.branch  = 1'b0;
            c.load    = 1'b0;
            c.store   = 1'b0;
        end
        c.exception = bad;
        return c;
    endfunction

    function automatic logic stall_rule();
        logic [4:0] s1;
        logic [4:0] s2;
        s1 = instr[19:15];
        s2 = instr[24:20];
        return valid_in &&
               ((hazard_0 != 5'd0 && (hazard_0 == s1 || hazard_0 == s2)) ||
                (hazard_1 != 5'd0 && (hazard_1 == s1 || hazard_1 == s2)));
    endfunction

    task automatic check_value(string name, logic [159:0] got, logic [159:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // Predict the register contents from the inputs present at the edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid <= 1'b0;
            exp_ctrl  <= '0;
        end else if (!stall_in) begin
            exp_valid <= valid_in && !stall_rule() && !invalidate;
            if (valid_in && !stall_rule() && !invalidate) begin
                exp_ctrl  <= predict_ctrl(instr);
                exp_ops   <= {pc_in, next_pc_in, rs1_data, rs2_data, build_imm(instr)};
                ops_known <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        check_value("rs1_select", 160'(rs1_select), 160'(instr[19:15]));
        check_value("rs2_select", 160'(rs2_select), 160'(instr[24:20]));
        check_value("stall_out", 160'(stall_out), 160'(stall_rule()));
        check_value("valid_out", 160'(valid_out), 160'(exp_valid));
        check_value("ctrl", 160'(ctrl), 160'(exp_ctrl));
        if (ops_known) begin
            check_value("ops", ops, exp_ops);
        end
    end

endmodule

// File: test/tb_decode.sv
`timescale 1ns/10ps

module tb_decode import decode_pkg::*; ();

    logic         clk = 1'b0;
    logic         arst_n;
    logic         valid_in;
    word_t        instr;
    word_t        pc_in;
    word_t        next_pc_in;
    logic         stall_in;
    logic         invalidate;
    reg_idx_t     hazard_0;
    reg_idx_t     hazard_1;
    reg_idx_t     rs1_select;
    reg_idx_t     rs2_select;
    word_t        rs1_data;
    word_t        rs2_data;
    logic         stall_out;
    logic         valid_out;
    decode_ctrl_t ctrl;
    decode_ops_t  ops;

    int tests      = 0;
    int bad_tests  = 0;
    int tb_errors  = 0;
    int last_total = 0;

    always #5 clk = ~clk;

    decode_stage decode_stage_i (.*);
    decode_checker decode_checker_i (.*);

    function automatic logic known_opcode(logic [6:0] op);
        return op inside {op_lui, op_auipc, op_jal, op_jalr, op_branch, op_load,
                          op_store, op_op_imm, op_op, op_fence, op_system};
    endfunction

    function automatic word_t legal_instr();
        word_t      i;
        logic [2:0] f3;
        i  = $urandom;
        f3 = i[14:12];
        case ($urandom_range(9))
            0: i[6:0] = op_lui;
            1: i[6:0] = op_auipc;
            2: i[6:0] = op_jal;
            3: i = {i[31:15], 3'd0, i[11:7], op_jalr};
            4: i = {i[31:15], (f3 inside {3'd2, 3'd3}) ? 3'd0 : f3, i[11:7], op_branch};
            5: i = {i[31:15], (f3 inside {3'd3, 3'd6, 3'd7}) ? 3'd4 : f3, i[11:7], op_load};
            6: i = {i[31:15], 1'b0, (f3[1:0] == 2'd3) ? 2'd2 : f3[1:0], i[11:7], op_store};
            7: i[6:0] = op_op_imm;
            8: i = {(f3 inside {3'd0, 3'd5}) ? {1'b0, i[30], 5'd0} : 7'd0, i[24:7], op_op};
            default: i = {i[31:15], 3'd0, i[11:7], op_fence};
        endcase
        return i;
    endfunction

    function automatic word_t illegal_instr();
        word_t i;
        i = $urandom;
        case ($urandom_range(7))
            0: i[6:0] = op_system;
            1: begin
                while (known_opcode(i[6:0])) i[6:0] = 7'($urandom);
            end
            2: i = {i[31:15], 3'd1 + 3'($urandom_range(6)), i[11:7], op_jalr};
            3: i = {i[31:15], 2'b01, i[12], i[11:7], op_branch};
            4: i = {i[31:15], ($urandom_range(1) == 1) ? 3'd6 : {i[14], 2'd3}, i[11:7], op_load};
            5: i = {i[31:15], (i[14:13] == 2'd0) ? 3'd3 : {1'b1, i[13:12]}, i[11:7], op_store};
            6: i = {i[31:15], 3'd1 + 3'($urandom_range(6)), i[11:7], op_fence};
            default: i = {7'h40 | 7'($urandom), i[24:7], op_op}; // Bit 31 set is never legal
        endcase
        return i;
    endfunction

    task automatic drive(word_t i, logic v, reg_idx_t h0, reg_idx_t h1, logic st, logic inv);
        @(posedge clk);
        #1;
        valid_in   = v;
        instr      = i;
        pc_in      = $urandom;
        next_pc_in = $urandom;
        rs1_data   = $urandom;
        rs2_data   = $urandom;
        hazard_0   = h0;
        hazard_1   = h1;
        stall_in   = st;
        invalidate = inv;
    endtask

    function automatic reg_idx_t pick_hazard(word_t i);
        case ($urandom_range(3))
            0: return 5'd0;
            1: return i[19:15];
            2: return i[24:20];
            default: return 5'($urandom);
        endcase
    endfunction

    task automatic end_test(string name);
        int n;
        drive(32'h0, 1'b0, 5'd0, 5'd0, 1'b0, 1'b0);
        n = 0;
        while (valid_out !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (valid_out !== 1'b0) begin
            tb_errors++;
            $display("Timeout waiting for valid_out to drop in test %s", name);
        end
        @(negedge clk);
        #1;
        tests++;
        if (decode_checker_i.errors + tb_errors != last_total) begin
            bad_tests++;
            $display("Test %s: FAIL with %0d errors", name,
                     decode_checker_i.errors + tb_errors - last_total);
        end else begin
            $display("Test %s: ok", name);
        end
        last_total = decode_checker_i.errors + tb_errors;
    endtask

    initial begin
        word_t i;
        void'($urandom(32'ha133_3f7c));
        arst_n = 1'b1;
        {valid_in, stall_in, invalidate} = '0;
        {instr, pc_in, next_pc_in, rs1_data, rs2_data} = '0;
        {hazard_0, hazard_1} = '0;
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        end_test("reset");

        repeat (400) drive(legal_instr(), 1'b1, 5'd0, 5'd0, 1'b0, 1'b0);
        end_test("legal_decode");

        repeat (200) drive(illegal_instr(), 1'b1, 5'd0, 5'd0, 1'b0, 1'b0);
        end_test("illegal_decode");

        repeat (300) begin
            i = legal_instr();
            drive(i, $urandom_range(3) != 0, pick_hazard(i), pick_hazard(i), 1'b0, 1'b0);
        end
        end_test("hazard_stall");

        repeat (400) begin
            i = ($urandom_range(4) == 0) ? illegal_instr() : legal_instr();
            drive(i, $urandom_range(3) != 0, pick_hazard(i), pick_hazard(i),
                  $urandom_range(9) < 3, $urandom_range(9) < 2);
        end
        end_test("backpressure_invalidate");

        $display("Tests: %0d run, %0d with errors, %0d checks, %0d mismatches, %0d other errors",
                 tests, bad_tests, decode_checker_i.checks, decode_checker_i.errors, tb_errors);
        if (bad_tests == 0 && decode_checker_i.errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: list.f
logic/decode_pkg.sv
logic/imm_gen.sv
logic/ctrl_decoder.sv
logic/decode_stage.sv
test/decode_checker.sv
test/tb_decode.sv

// File: run.sh
#!/bin/bash
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_decode -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -q "All tests passed" sim.log; then
    exit 0
else
    exit 1
fi
